//--- lsu_pkg.sv
//******************************
// Pipeline types for the LSU control path
// Shared by every RTL block and the testbench
//******************************

package lsu_pkg;

   // Widths with a meaning of their own
   typedef logic [31:0]        addr_t;
   typedef logic [31:0]        data_t;
   typedef logic signed [11:0] offset_t;
   typedef logic [63:0]        dma_data_t;
   typedef logic [2:0]         size_t;

   // Size codes as seen on the core and DMA request ports
   localparam size_t SZ_BYTE  = 3'd0;
   localparam size_t SZ_HALF  = 3'd1;
   localparam size_t SZ_WORD  = 3'd2;
   localparam size_t SZ_DWORD = 3'd3;

   // Stage registers between DC1 and DC5
   localparam int NUM_STAGES = 4;

   // Control packet that travels with each access
   typedef struct packed {
      logic valid;
      logic dma;
      logic unsign;
      logic store;
      logic load;
      logic by;
      logic half;
      logic word;
      logic dword;
   } lsu_pkt_t;

   // Per-stage valid control
   // kill spares DMA, freeze_kill clears any packet
   typedef struct packed {
      logic kill;
      logic hold;
      logic freeze_kill;
   } stage_ctl_t;

endpackage

//--- lsu_map_pkg.sv
//******************************
// Memory map and fault reporting
// Default DCCM and PIC windows, error packet layout
//******************************

package lsu_map_pkg;

   // Default region windows, aligned power-of-two sizes
   localparam lsu_pkg::addr_t DCCM_BASE_DEF = 32'hF004_0000;
   localparam lsu_pkg::addr_t DCCM_SIZE_DEF = 32'h0001_0000;
   localparam lsu_pkg::addr_t PIC_BASE_DEF  = 32'hF00C_0000;
   localparam lsu_pkg::addr_t PIC_SIZE_DEF  = 32'h0000_8000;

   // Encoding of exc_type
   localparam logic EXC_ACCESS     = 1'b1;
   localparam logic EXC_MISALIGNED = 1'b0;

   // Exception report from DC3
   // inst_type is 1 for a store
   typedef struct packed {
      logic           exc_valid;
      logic           exc_type;
      logic           inst_type;
      logic           dma_valid;
      lsu_pkg::addr_t addr;
   } lsu_error_pkt_t;

endpackage

//--- lsu_stage_if.sv
//******************************
// Contents of one LSU pipeline stage
// src drives a stage, dst reads it
//******************************
`timescale 1ns/1ps

interface lsu_stage_if;

   lsu_pkg::lsu_pkt_t pkt;
   lsu_pkg::addr_t    addr;
   lsu_pkg::addr_t    end_addr;
   lsu_pkg::data_t    store_data;

   // Region of the start address
   logic              in_dccm;
   logic              in_pic;
   logic              external;

   logic              access_fault;
   logic              misaligned_fault;

   modport src (
      output pkt, addr, end_addr, store_data,
      output in_dccm, in_pic, external,
      output access_fault, misaligned_fault
   );

   modport dst (
      input pkt, addr, end_addr, store_data,
      input in_dccm, in_pic, external,
      input access_fault, misaligned_fault
   );

endinterface

//--- lsu_agen.sv
//******************************
// DC1 entry of the LSU pipe
// Request premux, address generation, map check, stage controls
//******************************
`timescale 1ns/1ps

module lsu_agen #(
   parameter lsu_pkg::addr_t DCCM_BASE = lsu_map_pkg::DCCM_BASE_DEF,
   parameter lsu_pkg::addr_t DCCM_SIZE = lsu_map_pkg::DCCM_SIZE_DEF,
   parameter lsu_pkg::addr_t PIC_BASE  = lsu_map_pkg::PIC_BASE_DEF,
   parameter lsu_pkg::addr_t PIC_SIZE  = lsu_map_pkg::PIC_SIZE_DEF
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                lsu_valid_d,
   input  logic                lsu_store_d,
   input  logic                lsu_unsign_d,
   input  lsu_pkg::size_t      lsu_size_d,
   input  lsu_pkg::addr_t      rs1_d,
   input  lsu_pkg::offset_t    offset_d,
   input  lsu_pkg::data_t      store_data_d,
   input  logic                dma_dccm_req,
   input  lsu_pkg::addr_t      dma_mem_addr,
   input  lsu_pkg::size_t      dma_mem_sz,
   input  logic                dma_mem_write,
   input  lsu_pkg::dma_data_t  dma_mem_wdata,
   input  logic                flush_dc2_up,
   input  logic                flush_dc3,
   input  logic                flush_dc4,
   input  logic                lsu_freeze_dc3,
   lsu_stage_if.src            dc1,
   output lsu_pkg::stage_ctl_t stage_ctl [0:lsu_pkg::NUM_STAGES-1]
);

   lsu_pkg::lsu_pkt_t  pkt_d, pkt_dc1;
   lsu_pkg::addr_t     rs1_mux, rs1_dc1;
   lsu_pkg::offset_t   offset_mux, offset_dc1;
   lsu_pkg::dma_data_t dma_wdata_shifted;
   lsu_pkg::data_t     store_data_mux, store_data_dc1;
   logic               valid_dc1;
   lsu_pkg::addr_t     addr_dc1, end_addr_dc1;
   logic [2:0]         end_off;
   logic               unaligned;
   logic               start_dccm, start_pic, end_dccm, end_pic;

   function automatic lsu_pkg::lsu_pkt_t make_pkt(input logic valid, input logic dma,
                                                  input logic unsign, input logic store,
                                                  input lsu_pkg::size_t sz);
      lsu_pkg::lsu_pkt_t p;
      p.valid  = valid;
      p.dma    = dma;
      p.unsign = unsign;
      p.store  = store;
      p.load   = ~store;
      p.by     = (sz == lsu_pkg::SZ_BYTE);
      p.half   = (sz == lsu_pkg::SZ_HALF);
      p.word   = (sz == lsu_pkg::SZ_WORD);
      p.dword  = (sz == lsu_pkg::SZ_DWORD);
      return p;
   endfunction

   // Window test, base must be aligned to size
   function automatic logic in_window(input lsu_pkg::addr_t a, input lsu_pkg::addr_t base,
                                      input lsu_pkg::addr_t size);
      return (a & ~(size - 1'b1)) == base;
   endfunction

   //******************************
   // Request premux, DMA wins
   //******************************
   assign dma_wdata_shifted = dma_mem_wdata >> {dma_mem_addr[2:0], 3'b000};

   assign pkt_d = dma_dccm_req ?
                  make_pkt(1'b1, 1'b1, 1'b0, dma_mem_write, dma_mem_sz) :
                  make_pkt(lsu_valid_d & ~flush_dc2_up, 1'b0, lsu_unsign_d, lsu_store_d,
                           lsu_size_d);
   assign rs1_mux        = dma_dccm_req ? dma_mem_addr : rs1_d;
   assign offset_mux     = dma_dccm_req ? '0 : offset_d;
   assign store_data_mux = dma_dccm_req ? dma_wdata_shifted[31:0] : store_data_d;

   // DC1 registers, held while frozen
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_dc1 <= 1'b0;
      end else if (!lsu_freeze_dc3) begin
         valid_dc1 <= pkt_d.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (!lsu_freeze_dc3) begin
         pkt_dc1        <= pkt_d;
         rs1_dc1        <= rs1_mux;
         offset_dc1     <= offset_mux;
         store_data_dc1 <= store_data_mux;
      end
   end

   //******************************
   // Address and map check
   //******************************
   assign addr_dc1     = rs1_dc1 + {{20{offset_dc1[11]}}, offset_dc1};
   assign end_off      = pkt_dc1.dword ? 3'd7 : pkt_dc1.word ? 3'd3 : pkt_dc1.half ? 3'd1 : 3'd0;
   assign end_addr_dc1 = addr_dc1 + {29'b0, end_off};

   assign start_dccm = in_window(addr_dc1, DCCM_BASE, DCCM_SIZE);
   assign start_pic  = in_window(addr_dc1, PIC_BASE, PIC_SIZE);
   assign end_dccm   = in_window(end_addr_dc1, DCCM_BASE, DCCM_SIZE);
   assign end_pic    = in_window(end_addr_dc1, PIC_BASE, PIC_SIZE);

   assign unaligned = (pkt_dc1.half & addr_dc1[0]) | (pkt_dc1.word & |addr_dc1[1:0]) |
                      (pkt_dc1.dword & |addr_dc1[2:0]);

   always_comb begin
      dc1.pkt              = pkt_dc1;
      dc1.pkt.valid        = valid_dc1;
      dc1.addr             = addr_dc1;
      dc1.end_addr         = end_addr_dc1;
      dc1.store_data       = store_data_dc1;
      dc1.in_dccm          = start_dccm;
      dc1.in_pic           = start_pic;
      dc1.external         = ~start_dccm & ~start_pic;
      // DCCM takes unaligned accesses, other space does not
      dc1.misaligned_fault = valid_dc1 & ((unaligned & ~start_dccm) |
                                          (start_dccm != end_dccm) | (start_pic != end_pic));
      // PIC registers are word access only
      dc1.access_fault     = valid_dc1 & start_pic & ~pkt_dc1.word;
   end

   // Stage controls, index 0 feeds DC2
   assign stage_ctl[0] = '{kill: flush_dc2_up, hold: lsu_freeze_dc3, freeze_kill: 1'b0};
   assign stage_ctl[1] = '{kill: flush_dc2_up, hold: lsu_freeze_dc3, freeze_kill: 1'b0};
   assign stage_ctl[2] = '{kill: flush_dc3, hold: 1'b0, freeze_kill: lsu_freeze_dc3};
   assign stage_ctl[3] = '{kill: flush_dc4, hold: 1'b0, freeze_kill: 1'b0};

endmodule

//--- lsu_pipe_stage.sv
//******************************
// One LSU pipe register stage
// Flush kills core packets, hold freezes the stage
//******************************
`timescale 1ns/1ps

module lsu_pipe_stage (
   input  logic                clk,
   input  logic                arst_n,
   input  lsu_pkg::stage_ctl_t ctl,
   lsu_stage_if.dst            prev,
   lsu_stage_if.src            next
);

   logic              valid_d;
   logic              valid_q;
   lsu_pkg::lsu_pkt_t pkt_q;
   lsu_pkg::addr_t    addr_q;
   lsu_pkg::addr_t    end_addr_q;
   lsu_pkg::data_t    store_data_q;
   logic              in_dccm_q, in_pic_q, external_q;
   logic              access_fault_q, misaligned_fault_q;

   // DMA survives a flush but not a freeze bubble
   assign valid_d = prev.pkt.valid & ~(ctl.kill & ~prev.pkt.dma) & ~ctl.freeze_kill;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= 1'b0;
      end else if (!ctl.hold) begin
         valid_q <= valid_d;
      end
   end

   always_ff @(posedge clk) begin
      if (!ctl.hold) begin
         pkt_q              <= prev.pkt;
         addr_q             <= prev.addr;
         end_addr_q         <= prev.end_addr;
         store_data_q       <= prev.store_data;
         in_dccm_q          <= prev.in_dccm;
         in_pic_q           <= prev.in_pic;
         external_q         <= prev.external;
         access_fault_q     <= prev.access_fault;
         misaligned_fault_q <= prev.misaligned_fault;
      end
   end

   always_comb begin
      next.pkt              = pkt_q;
      next.pkt.valid        = valid_q;
      next.addr             = addr_q;
      next.end_addr         = end_addr_q;
      next.store_data       = store_data_q;
      next.in_dccm          = in_dccm_q;
      next.in_pic           = in_pic_q;
      next.external         = external_q;
      next.access_fault     = access_fault_q;
      next.misaligned_fault = misaligned_fault_q;
   end

endmodule

//--- lsu_retire.sv
//******************************
// Retire side of the LSU pipe
// DC3 load result and error report, DC2 exception, DC5 commit
//******************************
`timescale 1ns/1ps

module lsu_retire (
   lsu_stage_if.dst                    dc2,
   lsu_stage_if.dst                    dc3,
   lsu_stage_if.dst                    dc5,
   input  lsu_pkg::data_t              lsu_ld_data_dc3,
   input  lsu_pkg::data_t              bus_read_data_dc3,
   input  logic                        flush_dc3,
   input  logic                        flush_dc5,
   input  logic                        lsu_freeze_dc3,
   output lsu_pkg::data_t              lsu_result_dc3,
   output lsu_map_pkg::lsu_error_pkt_t lsu_error_pkt_dc3,
   output logic                        lsu_exc_dc2,
   output logic                        lsu_freeze_external_ints_dc3,
   output logic                        lsu_commit_dc5
);

   lsu_pkg::data_t data_sel;
   logic           fault_dc3;

   //******************************
   // Load formatting
   //******************************
   assign data_sel = dc3.external ? bus_read_data_dc3 : lsu_ld_data_dc3;

   always_comb begin
      if (dc3.pkt.by) begin
         lsu_result_dc3 = dc3.pkt.unsign ? {24'b0, data_sel[7:0]} :
                                           {{24{data_sel[7]}}, data_sel[7:0]};
      end else if (dc3.pkt.half) begin
         lsu_result_dc3 = dc3.pkt.unsign ? {16'b0, data_sel[15:0]} :
                                           {{16{data_sel[15]}}, data_sel[15:0]};
      end else begin
         lsu_result_dc3 = data_sel;
      end
   end

   //******************************
   // Exceptions
   //******************************
   assign fault_dc3 = dc3.access_fault | dc3.misaligned_fault;

   always_comb begin
      lsu_error_pkt_dc3.exc_valid = fault_dc3 & dc3.pkt.valid & ~dc3.pkt.dma & ~flush_dc3;
      // Misaligned reported ahead of access
      lsu_error_pkt_dc3.exc_type  = dc3.misaligned_fault ? lsu_map_pkg::EXC_MISALIGNED :
                                                           lsu_map_pkg::EXC_ACCESS;
      lsu_error_pkt_dc3.inst_type = dc3.pkt.store;
      lsu_error_pkt_dc3.dma_valid = dc3.pkt.dma;
      lsu_error_pkt_dc3.addr      = dc3.addr;
   end

   assign lsu_exc_dc2 = dc2.access_fault | dc2.misaligned_fault;

   // Only external space has side effects
   assign lsu_freeze_external_ints_dc3 = lsu_freeze_dc3 & dc3.external;

   // A flush at DC5 still lets DMA write back
   assign lsu_commit_dc5 = dc5.pkt.valid & ~(flush_dc5 & ~dc5.pkt.dma);

endmodule

//--- lsu_lsc_ctl.sv
//******************************
// LSU control datapath, DC1 to DC5 with commit at DC5
// Feeder, four stage registers and retire logic
//******************************
`timescale 1ns/1ps

module lsu_lsc_ctl #(
   parameter lsu_pkg::addr_t DCCM_BASE = lsu_map_pkg::DCCM_BASE_DEF,
   parameter lsu_pkg::addr_t DCCM_SIZE = lsu_map_pkg::DCCM_SIZE_DEF,
   parameter lsu_pkg::addr_t PIC_BASE  = lsu_map_pkg::PIC_BASE_DEF,
   parameter lsu_pkg::addr_t PIC_SIZE  = lsu_map_pkg::PIC_SIZE_DEF
) (
   input  logic               clk,
   input  logic               arst_n,
   // Core request
   input  logic               lsu_valid_d,
   input  logic               lsu_store_d,
   input  logic               lsu_unsign_d,
   input  lsu_pkg::size_t     lsu_size_d,
   input  lsu_pkg::addr_t     rs1_d,
   input  lsu_pkg::offset_t   offset_d,
   input  lsu_pkg::data_t     store_data_d,
   // DMA request
   input  logic               dma_dccm_req,
   input  lsu_pkg::addr_t     dma_mem_addr,
   input  lsu_pkg::size_t     dma_mem_sz,
   input  logic               dma_mem_write,
   input  lsu_pkg::dma_data_t dma_mem_wdata,
   // Pipe control
   input  logic               flush_dc2_up,
   input  logic               flush_dc3,
   input  logic               flush_dc4,
   input  logic               flush_dc5,
   input  logic               lsu_freeze_dc3,
   // Load data in DC3
   input  lsu_pkg::data_t     lsu_ld_data_dc3,
   input  lsu_pkg::data_t     bus_read_data_dc3,
   output lsu_pkg::addr_t     lsu_addr_dc1,
   output lsu_pkg::addr_t     lsu_addr_dc5,
   output lsu_pkg::addr_t     end_addr_dc5,
   output lsu_pkg::data_t     store_data_dc5,
   output logic               addr_in_dccm_dc3,
   output logic               addr_in_pic_dc3,
   output logic               addr_external_dc5,
   output lsu_pkg::data_t     lsu_result_dc3,
   output logic               exc_valid_dc3,
   output logic               exc_type_dc3,
   output logic               exc_dma_dc3,
   output lsu_pkg::addr_t     exc_addr_dc3,
   output logic               lsu_exc_dc2,
   output logic               lsu_freeze_external_ints_dc3,
   output logic               lsu_commit_dc5
);

   localparam int LAST = lsu_pkg::NUM_STAGES;

   // st[0] is DC1, st[LAST] is DC5
   lsu_stage_if st [0:LAST] ();

   lsu_pkg::stage_ctl_t         stage_ctl [0:LAST-1];
   lsu_map_pkg::lsu_error_pkt_t error_pkt_dc3;

   lsu_agen #(
      .DCCM_BASE (DCCM_BASE),
      .DCCM_SIZE (DCCM_SIZE),
      .PIC_BASE  (PIC_BASE),
      .PIC_SIZE  (PIC_SIZE)
   ) u_agen (
      .clk, .arst_n,
      .lsu_valid_d, .lsu_store_d, .lsu_unsign_d, .lsu_size_d,
      .rs1_d, .offset_d, .store_data_d,
      .dma_dccm_req, .dma_mem_addr, .dma_mem_sz, .dma_mem_write, .dma_mem_wdata,
      .flush_dc2_up, .flush_dc3, .flush_dc4, .lsu_freeze_dc3,
      .dc1       (st[0]),
      .stage_ctl (stage_ctl)
   );

   for (genvar g = 0; g < LAST; g++) begin : g_stage
      lsu_pipe_stage u_stage (
         .clk  (clk),
         .arst_n (arst_n),
         .ctl  (stage_ctl[g]),
         .prev (st[g]),
         .next (st[g+1])
      );
   end

   lsu_retire u_retire (
      .dc2 (st[1]),
      .dc3 (st[2]),
      .dc5 (st[LAST]),
      .lsu_ld_data_dc3, .bus_read_data_dc3,
      .flush_dc3, .flush_dc5, .lsu_freeze_dc3,
      .lsu_result_dc3,
      .lsu_error_pkt_dc3 (error_pkt_dc3),
      .lsu_exc_dc2, .lsu_freeze_external_ints_dc3, .lsu_commit_dc5
   );

   assign lsu_addr_dc1      = st[0].addr;
   assign lsu_addr_dc5      = st[LAST].addr;
   assign end_addr_dc5      = st[LAST].end_addr;
   assign store_data_dc5    = st[LAST].store_data;
   assign addr_external_dc5 = st[LAST].external;
   assign addr_in_dccm_dc3  = st[2].in_dccm;
   assign addr_in_pic_dc3   = st[2].in_pic;

   assign exc_valid_dc3 = error_pkt_dc3.exc_valid;
   assign exc_type_dc3  = error_pkt_dc3.exc_type;
   assign exc_dma_dc3   = error_pkt_dc3.dma_valid;
   assign exc_addr_dc3  = error_pkt_dc3.addr;

endmodule

//--- lsu_lsc_ctl_asserts.sv
//******************************
// Concurrent checks on the LSU control top level
// Bound into every instance of lsu_lsc_ctl
//******************************
`timescale 1ns/1ps

module lsu_lsc_ctl_asserts (
   input logic           clk,
   input logic           arst_n,
   input logic           lsu_freeze_dc3,
   input lsu_pkg::addr_t lsu_addr_dc1,
   input lsu_pkg::addr_t lsu_addr_dc5,
   input logic           exc_valid_dc3,
   input logic           exc_dma_dc3,
   input logic           lsu_exc_dc2,
   input logic           lsu_commit_dc5
);

   // Cycles since reset release, saturating
   logic [2:0] cyc;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cyc <= 3'd0;
      end else if (cyc != 3'd7) begin
         cyc <= cyc + 3'd1;
      end
   end

   no_early_commit: assert property (@(posedge clk) disable iff (!arst_n)
      (cyc < 3'd5) |-> !lsu_commit_dc5)
      else $error("commit within five cycles of reset");

   // A reported fault came through DC2 or is being held in DC3
   exc_has_fault: assert property (@(posedge clk) disable iff (!arst_n)
      exc_valid_dc3 |-> (!exc_dma_dc3 && ($past(lsu_exc_dc2) || $past(exc_valid_dc3))))
      else $error("exception without fault or on a DMA access");

   addr_travels: assert property (@(posedge clk) disable iff (!arst_n)
      ((cyc >= 3'd6) && !$past(lsu_freeze_dc3, 1) && !$past(lsu_freeze_dc3, 2) &&
       !$past(lsu_freeze_dc3, 3) && !$past(lsu_freeze_dc3, 4))
      |-> (lsu_addr_dc5 == $past(lsu_addr_dc1, 4)))
      else $error("DC5 address does not match DC1 address four cycles back");

endmodule

bind lsu_lsc_ctl lsu_lsc_ctl_asserts u_asserts (
   .clk            (clk),
   .arst_n         (arst_n),
   .lsu_freeze_dc3 (lsu_freeze_dc3),
   .lsu_addr_dc1   (lsu_addr_dc1),
   .lsu_addr_dc5   (lsu_addr_dc5),
   .exc_valid_dc3  (exc_valid_dc3),
   .exc_dma_dc3    (exc_dma_dc3),
   .lsu_exc_dc2    (lsu_exc_dc2),
   .lsu_commit_dc5 (lsu_commit_dc5)
);

//--- tb_lsu_lsc_ctl.sv
//******************************
// Testbench for the LSU control path
// Runs the transactions of lsu_stim.txt one at a time
//******************************
`timescale 1ns/1ps

module tb_lsu_lsc_ctl;

   localparam int MAX_TX = 64;

   logic clk, arst_n;
   logic lsu_valid_d, lsu_store_d, lsu_unsign_d, dma_dccm_req, dma_mem_write;
   lsu_pkg::size_t lsu_size_d, dma_mem_sz;
   lsu_pkg::addr_t rs1_d, dma_mem_addr;
   lsu_pkg::offset_t offset_d;
   lsu_pkg::data_t store_data_d, lsu_ld_data_dc3, bus_read_data_dc3;
   lsu_pkg::dma_data_t dma_mem_wdata;
   logic flush_dc2_up, flush_dc3, flush_dc4, flush_dc5, lsu_freeze_dc3;
   lsu_pkg::addr_t lsu_addr_dc1, lsu_addr_dc5, end_addr_dc5, exc_addr_dc3;
   lsu_pkg::data_t store_data_dc5, lsu_result_dc3;
   logic addr_in_dccm_dc3, addr_in_pic_dc3, addr_external_dc5;
   logic exc_valid_dc3, exc_type_dc3, exc_dma_dc3;
   logic lsu_exc_dc2, lsu_freeze_external_ints_dc3, lsu_commit_dc5;

   // Transactions as read from the stimulus file
   int                 t_src [MAX_TX];
   int                 t_store [MAX_TX];
   int                 t_uns [MAX_TX];
   int                 t_size [MAX_TX];
   lsu_pkg::addr_t     t_rs1 [MAX_TX];
   int                 t_off [MAX_TX];
   lsu_pkg::dma_data_t t_wdata [MAX_TX];
   lsu_pkg::data_t     t_dccm [MAX_TX];
   lsu_pkg::data_t     t_bus [MAX_TX];
   int                 t_flush [MAX_TX];
   int                 t_frz [MAX_TX];
   lsu_pkg::addr_t     t_eaddr [MAX_TX];
   lsu_pkg::data_t     t_eres [MAX_TX];
   int                 t_efault [MAX_TX];

   int n_tx, n_err, n_checks, tx_err;
   bit load_done;

   lsu_lsc_ctl u_lsu_lsc_ctl (.*);

   always #50 clk = ~clk;

   //******************************
   // Compare tasks
   //******************************
   task automatic check_addr(input string what, input lsu_pkg::addr_t got,
                             input lsu_pkg::addr_t exp);
      n_checks++;
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         n_err++;
         tx_err++;
      end
   endtask

   task automatic check_data(input string what, input lsu_pkg::data_t got,
                             input lsu_pkg::data_t exp);
      n_checks++;
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         n_err++;
         tx_err++;
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      n_checks++;
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
         n_err++;
         tx_err++;
      end
   endtask

   //******************************
   // Reference model
   //******************************
   function automatic logic in_range(input lsu_pkg::addr_t a, input lsu_pkg::addr_t base,
                                     input lsu_pkg::addr_t size);
      return (a >= base) && (a < base + size);
   endfunction

   function automatic logic is_dccm(input lsu_pkg::addr_t a);
      return in_range(a, lsu_map_pkg::DCCM_BASE_DEF, lsu_map_pkg::DCCM_SIZE_DEF);
   endfunction

   function automatic logic is_pic(input lsu_pkg::addr_t a);
      return in_range(a, lsu_map_pkg::PIC_BASE_DEF, lsu_map_pkg::PIC_SIZE_DEF);
   endfunction

   // 0 none, 1 access, 2 misaligned
   function automatic int fault_code(input lsu_pkg::addr_t a, input int size);
      lsu_pkg::addr_t e;
      lsu_pkg::addr_t mask;
      e = a + lsu_pkg::addr_t'((1 << size) - 1);
      mask = lsu_pkg::addr_t'((1 << size) - 1);
      if ((((a & mask) != 0) && !is_dccm(a)) || (is_dccm(a) != is_dccm(e)) ||
          (is_pic(a) != is_pic(e)))
         return 2;
      if (is_pic(a) && (size != 2))
         return 1;
      return 0;
   endfunction

   function automatic lsu_pkg::data_t load_value(input int i, input lsu_pkg::addr_t a);
      lsu_pkg::data_t d;
      logic uns;
      d = (!is_dccm(a) && !is_pic(a)) ? t_bus[i] : t_dccm[i];
      uns = (t_src[i] == 0) ? (t_uns[i] != 0) : 1'b0;
      case (t_size[i])
         0: return uns ? {24'h0, d[7:0]} : {{24{d[7]}}, d[7:0]};
         1: return uns ? {16'h0, d[15:0]} : {{16{d[15]}}, d[15:0]};
         default: return d;
      endcase
   endfunction

   function automatic lsu_pkg::data_t store_value(input int i, input lsu_pkg::addr_t a);
      lsu_pkg::dma_data_t w;
      w = (t_src[i] != 0) ? (t_wdata[i] >> (8 * a[2:0])) : t_wdata[i];
      return w[31:0];
   endfunction

   //******************************
   // One transaction through DC1 to DC5
   //******************************
   task automatic run_tx(input int i);
      lsu_pkg::addr_t a;
      lsu_pkg::data_t res;
      int fault, dc5_k, last_k, fl;
      logic dma, in_dc3, exc_exp;
      tx_err = 0;
      dma = (t_src[i] != 0);
      fl = t_flush[i];
      a = dma ? t_rs1[i] : t_rs1[i] + lsu_pkg::addr_t'(t_off[i]);
      fault = fault_code(a, t_size[i]);
      res = (t_store[i] != 0) ? store_value(i, a) : load_value(i, a);
      if (a !== t_eaddr[i] || res !== t_eres[i] || fault != t_efault[i]) begin
         $display("Stimulus line of test %0d disagrees with the reference model", i);
         n_err++;
         tx_err++;
      end
      dc5_k = (t_frz[i] != 0) ? 7 : 5;
      last_k = dc5_k + 1;

      @(negedge clk);
      lsu_valid_d = (t_src[i] != 1);
      dma_dccm_req = dma;
      lsu_store_d = (t_store[i] != 0);
      dma_mem_write = (t_store[i] != 0);
      lsu_unsign_d = (t_uns[i] != 0);
      lsu_size_d = lsu_pkg::size_t'(t_size[i]);
      dma_mem_sz = lsu_pkg::size_t'(t_size[i]);
      // Core address differs so that the DMA win shows
      rs1_d = (t_src[i] == 2) ? t_rs1[i] + 32'h100 : t_rs1[i];
      offset_d = lsu_pkg::offset_t'(t_off[i]);
      dma_mem_addr = t_rs1[i];
      store_data_d = t_wdata[i][31:0];
      dma_mem_wdata = t_wdata[i];
      lsu_ld_data_dc3 = '0;
      bus_read_data_dc3 = '0;

      for (int k = 1; k <= last_k; k++) begin
         @(negedge clk);
         lsu_valid_d = 1'b0;
         dma_dccm_req = 1'b0;
         flush_dc2_up = (fl == 2) && (k == 1);
         flush_dc3 = (fl == 3) && (k == 3);
         flush_dc4 = (fl == 4) && (k == 4);
         flush_dc5 = (fl == 5) && (k == dc5_k);
         lsu_freeze_dc3 = (t_frz[i] != 0) && (k == 3 || k == 4);
         in_dc3 = (k >= 3) && (k <= dc5_k - 2);
         // Load data only while the access sits in DC3
         lsu_ld_data_dc3 = in_dc3 ? t_dccm[i] : '0;
         bus_read_data_dc3 = in_dc3 ? t_bus[i] : '0;
         #1;
         exc_exp = in_dc3 && (fault != 0) && !dma && (fl != 2) && (fl != 3);
         if (k == 1)
            check_addr("lsu_addr_dc1", lsu_addr_dc1, a);
         if (k == 2 && fl != 2)
            check_bit("lsu_exc_dc2", lsu_exc_dc2, fault != 0);
         if (in_dc3) begin
            if (t_store[i] == 0)
               check_data("lsu_result_dc3", lsu_result_dc3, res);
            check_bit("addr_in_dccm_dc3", addr_in_dccm_dc3, is_dccm(a));
            check_bit("addr_in_pic_dc3", addr_in_pic_dc3, is_pic(a));
            check_bit("exc_dma_dc3", exc_dma_dc3, dma);
         end
         check_bit("exc_valid_dc3", exc_valid_dc3, exc_exp);
         if (exc_exp) begin
            check_bit("exc_type_dc3", exc_type_dc3, fault == 1);
            check_addr("exc_addr_dc3", exc_addr_dc3, a);
         end
         check_bit("lsu_freeze_external_ints_dc3", lsu_freeze_external_ints_dc3,
                   lsu_freeze_dc3 && !is_dccm(a) && !is_pic(a));
         check_bit("lsu_commit_dc5", lsu_commit_dc5, (k == dc5_k) && (fl == 0 || dma));
         if (k == dc5_k) begin
            check_addr("lsu_addr_dc5", lsu_addr_dc5, a);
            check_addr("end_addr_dc5", end_addr_dc5,
                       a + lsu_pkg::addr_t'((1 << t_size[i]) - 1));
            check_bit("addr_external_dc5", addr_external_dc5, !is_dccm(a) && !is_pic(a));
            if (t_store[i] != 0)
               check_data("store_data_dc5", store_data_dc5, res);
         end
      end
      $display("test %0d at address %h: %s", i, a, (tx_err == 0) ? "ok" : "FAILED");
   endtask

   // Stops a run that outlives its transactions
   initial begin
      wait (load_done);
      #((n_tx * 20 + 5) * 100);
      $display("Timeout: simulation ran past its time limit");
      $display("Test failed");
      $finish;
   end

   initial begin
      int fd, cnt, gap;
      string line;
      clk = 1'b0;
      arst_n = 1'b0;
      {lsu_valid_d, lsu_store_d, lsu_unsign_d, dma_dccm_req, dma_mem_write} = '0;
      lsu_size_d = '0;
      dma_mem_sz = '0;
      rs1_d = '0;
      offset_d = '0;
      store_data_d = '0;
      dma_mem_addr = '0;
      dma_mem_wdata = '0;
      {flush_dc2_up, flush_dc3, flush_dc4, flush_dc5, lsu_freeze_dc3} = '0;
      lsu_ld_data_dc3 = '0;
      bus_read_data_dc3 = '0;
      n_tx = 0;
      n_err = 0;
      n_checks = 0;
      gap = $urandom(32'hf0e1_4783);

      fd = $fopen("lsu_stim.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file lsu_stim.txt");
         $display("Test failed");
         $finish;
      end else begin
         while (!$feof(fd) && n_tx < MAX_TX) begin
            line = "";
            cnt = $fgets(line, fd);
            if (line.len() > 1 && line[0] != 8'h23) begin
               cnt = $sscanf(line, "%d %d %d %d %h %d %h %h %h %d %d %h %h %d",
                             t_src[n_tx], t_store[n_tx], t_uns[n_tx], t_size[n_tx],
                             t_rs1[n_tx], t_off[n_tx], t_wdata[n_tx], t_dccm[n_tx],
                             t_bus[n_tx], t_flush[n_tx], t_frz[n_tx], t_eaddr[n_tx],
                             t_eres[n_tx], t_efault[n_tx]);
               if (cnt == 14) begin
                  n_tx++;
               end else begin
                  $display("Malformed stimulus line: %s", line);
                  n_err++;
               end
            end
         end
         $fclose(fd);
         load_done = 1'b1;

         repeat (5) @(posedge clk);
         @(negedge clk);
         arst_n = 1'b1;
         repeat (2) @(negedge clk);

         for (int i = 0; i < n_tx; i++) begin
            gap = $urandom % 3;
            repeat (gap) @(negedge clk);
            run_tx(i);
         end

         $display("%0d tests, %0d checks, %0d errors", n_tx, n_checks, n_err);
         if (n_err == 0) begin
            $display("Test completed successfully");
         end else begin
            $display("Test failed");
         end
         $finish;
      end
   end

endmodule

//--- lsu_stim.txt
# src(0 core,1 dma,2 both) store unsign size rs1 offset wdata dccm bus flush freeze
# expected: addr result(load data or store data) fault(0 none,1 access,2 misaligned)
0 0 0 2 f0040100 -8 0 8badf00d 11111111 0 0 f00400f8 8badf00d 0
0 0 0 0 f0040100 5 0 000000a5 0 0 0 f0040105 ffffffa5 0
0 0 1 0 f0040100 6 0 000000a5 0 0 0 f0040106 000000a5 0
0 0 0 1 f0040200 2 0 12348001 0 0 0 f0040202 ffff8001 0
0 0 1 1 00001000 16 0 deadbeef 0000f00f 0 0 00001010 0000f00f 0
0 0 0 2 20000000 4 0 deadbeef cafef00d 0 0 20000004 cafef00d 0
0 0 0 2 f0040800 -2048 0 80000000 0 0 0 f0040000 80000000 0
0 1 0 2 f0040010 4 55aa33cc 0 0 0 0 f0040014 55aa33cc 0
0 1 0 0 30000000 -1 ab 0 0 0 0 2fffffff 000000ab 0
1 1 0 2 f0040104 0 1122334455667788 0 0 0 0 f0040104 11223344 0
1 0 0 2 f0040300 0 0 0badcafe 0 0 0 f0040300 0badcafe 0
2 0 0 2 f0040400 12 0 01020304 0 0 0 f0040400 01020304 0
# Faults
0 0 0 2 40000000 2 0 0 0 0 0 40000002 00000000 2
0 0 0 1 f00c0000 4 0 0 0 0 0 f00c0004 00000000 1
0 0 0 2 f004fffc 2 0 0 0 0 0 f004fffe 00000000 2
1 0 0 2 40000001 0 0 0 0 0 0 40000001 00000000 2
1 0 0 1 f00c0010 0 0 0 0 0 0 f00c0010 00000000 1
# Flushes
0 0 0 2 f0040020 0 0 00000001 0 2 0 f0040020 00000001 0
0 1 0 2 f0040024 0 abcd0123 0 0 3 0 f0040024 abcd0123 0
0 0 0 2 f0040028 0 0 00000077 0 4 0 f0040028 00000077 0
0 1 0 2 f004002c 0 0000beef 0 0 5 0 f004002c 0000beef 0
1 1 0 2 f0040030 0 00000000deadbeef 0 0 5 0 f0040030 deadbeef 0
1 0 0 2 f0040034 0 0 00000042 0 3 0 f0040034 00000042 0
# Freezes
0 0 0 2 50000000 8 0 0 76543210 0 1 50000008 76543210 0
0 0 0 2 f0040040 0 0 13579bdf 0 0 1 f0040040 13579bdf 0

//--- sim.f
lsu_pkg.sv
lsu_map_pkg.sv
lsu_stage_if.sv
lsu_agen.sv
lsu_pipe_stage.sv
lsu_retire.sv
lsu_lsc_ctl.sv
lsu_lsc_ctl_asserts.sv
tb_lsu_lsc_ctl.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu_lsc_ctl \
		--Mdir obj_dir -f sim.f
	./obj_dir/Vtb_lsu_lsc_ctl > $(LOG) 2>&1; cat $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
